/* sources.f */
rtl/an_regs_pkg.sv
rtl/host_bus_ctrl.sv
rtl/an_control_reg.sv
rtl/adv_ability_reg.sv
rtl/an_status_regs.sv
rtl/an_reg_top.sv
sim/an_reg_checker.sv
sim/an_reg_assertions.sv
sim/tb_an_reg_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_an_reg_top -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_an_reg_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
	exit 0
fi
exit 1

/* sim/tb_an_reg_top.sv */
`timescale 1ns/1ps

module tb_an_reg_top
	import an_regs_pkg::*;
();

	localparam int CLK_PERIOD       = 100;
	localparam int DRIVE_DELAY      = 10;
	localparam int SETTLE_CYCLES    = 12;
	// Idle time between accesses outlasts the page clear delay
	localparam int GAP_CYCLES       = 6;
	localparam int CYCLES_PER_ENTRY = 30;
	localparam int WATCHDOG_MARGIN  = 200;
	localparam logic [31:0] SEED    = 32'haff48bf8;
	localparam logic OP_RD = 1'b0;
	localparam logic OP_WR = 1'b1;

	logic       clk, rst_n, sgmii_mode;
	logic       hcs_n, hwrite_n, hready_n;
	host_addr_t haddr;
	host_data_t hdatain, hdataout;
	logic       mr_an_complete, mr_page_rx;
	mii_reg_t   mr_lp_adv_ability, mr_adv_ability;
	logic       mr_main_reset, mr_an_enable, mr_restart_an;

	// Stimulus table with one queue per column
	logic       t_wr[$], t_mode[$], t_page[$], t_cmpl[$], t_en[$], t_pulse[$];
	host_addr_t t_addr[$];
	host_data_t t_wdata[$], t_exp[$];
	mii_reg_t   t_adv[$];
	int         n_entries;
	logic [31:0] lcg_state;

	// Expectation of the access in flight for the checker
	int         cur_idx;
	logic       cur_rd, cur_en, cur_pulse, all_done;
	host_data_t cur_exp;
	mii_reg_t   cur_adv;
	int         err_count, test_count;

	an_reg_top i_an_reg_top (.*);

	an_reg_checker i_an_reg_checker (
		.clk            (clk),
		.rst_n          (rst_n),
		.hready_n       (hready_n),
		.hdataout       (hdataout),
		.mr_main_reset  (mr_main_reset),
		.mr_restart_an  (mr_restart_an),
		.mr_an_enable   (mr_an_enable),
		.mr_adv_ability (mr_adv_ability),
		.test_idx       (cur_idx),
		.test_rd        (cur_rd),
		.exp_byte       (cur_exp),
		.exp_en         (cur_en),
		.exp_adv        (cur_adv),
		.exp_pulse      (cur_pulse),
		.all_done       (all_done),
		.err_count      (err_count),
		.test_count     (test_count)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic add_entry(input logic wr, input host_addr_t addr, input host_data_t data,
		input logic mode, input logic page, input logic cmpl, input host_data_t exp_rd,
		input logic en, input mii_reg_t adv, input logic pulse);
		t_wr.push_back(wr);
		t_addr.push_back(addr);
		t_wdata.push_back(data);
		t_mode.push_back(mode);
		t_page.push_back(page);
		t_cmpl.push_back(cmpl);
		t_exp.push_back(exp_rd);
		t_en.push_back(en);
		t_adv.push_back(adv);
		t_pulse.push_back(pulse);
	endtask

	// Holds chip select low until ready is seen
	// Entered just after a clock edge
	task automatic bus_access(input logic wr, input host_addr_t addr, input host_data_t data);
		hcs_n    = 1'b0;
		hwrite_n = ~wr;
		haddr    = addr;
		hdatain  = data;
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
		end while (hready_n);
		hcs_n    = 1'b1;
		hwrite_n = 1'b1;
	endtask

	task automatic host_write(input host_addr_t addr, input host_data_t data);
		bus_access(OP_WR, addr, data);
	endtask

	task automatic host_read(input host_addr_t addr);
		bus_access(OP_RD, addr, 8'h00);
	endtask

	task automatic run_entry(input int i);
		repeat (GAP_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		// Mode change needs the reload to land first
		if (sgmii_mode !== t_mode[i]) begin
			sgmii_mode = t_mode[i];
			repeat (SETTLE_CYCLES) @(posedge clk);
			#DRIVE_DELAY;
		end
		mr_an_complete = t_cmpl[i];
		if (t_page[i]) begin
			mr_page_rx = 1'b1;
			@(posedge clk);
			#DRIVE_DELAY;
			mr_page_rx = 1'b0;
		end
		cur_idx   = i;
		cur_rd    = ~t_wr[i];
		cur_exp   = t_exp[i];
		cur_en    = t_en[i];
		cur_adv   = t_adv[i];
		cur_pulse = t_pulse[i];
		if (t_wr[i])
			host_write(t_addr[i], t_wdata[i]);
		else
			host_read(t_addr[i]);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		sgmii_mode = 1'b0;
		hcs_n = 1'b1;
		hwrite_n = 1'b1;
		haddr = '0;
		hdatain = '0;
		mr_an_complete = 1'b0;
		mr_page_rx = 1'b0;
		all_done = 1'b0;
		cur_idx = 0;
		cur_rd = 1'b0;
		cur_exp = '0;
		cur_en = 1'b1;
		cur_adv = ADV_RESET_VALUE;
		cur_pulse = 1'b0;
		lcg_state = lcg_next(SEED);
		mr_lp_adv_ability = lcg_state[31:16];

		// wr, addr, wdata, mode, page, cmpl, read byte, an_enable, adv, pulse
		// Defaults with every zero read placed after a nonzero one
		add_entry(OP_RD, ADDR_CTRL_HI, 8'h00, 1'b0, 1'b0, 1'b0, 8'h10, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_CTRL_LO, 8'h00, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_ADV_LO,  8'h00, 1'b0, 1'b0, 1'b0, 8'h01, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, 4'd5,         8'h00, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_ADV_HI,  8'h00, 1'b0, 1'b0, 1'b0, 8'h40, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, 4'd14,        8'h00, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1, 16'h4001, 1'b0);
		// Main reset and restart both clear themselves
		add_entry(OP_WR, ADDR_CTRL_HI, 8'h82, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0, 16'h4001, 1'b1);
		add_entry(OP_RD, ADDR_CTRL_HI, 8'h00, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0, 16'h4001, 1'b0);
		add_entry(OP_WR, ADDR_CTRL_HI, 8'h10, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_CTRL_HI, 8'h00, 1'b0, 1'b0, 1'b0, 8'h10, 1'b1, 16'h4001, 1'b0);
		// MAC side ignores the write
		add_entry(OP_WR, ADDR_ADV_LO,  8'h33, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_ADV_LO,  8'h00, 1'b0, 1'b0, 1'b0, 8'h01, 1'b1, 16'h4001, 1'b0);
		// PHY side reload followed by a write
		add_entry(OP_RD, ADDR_ADV_LO,  8'h00, 1'b1, 1'b0, 1'b0, 8'h01, 1'b1, 16'hd801, 1'b0);
		add_entry(OP_RD, ADDR_ADV_HI,  8'h00, 1'b1, 1'b0, 1'b0, 8'hd8, 1'b1, 16'hd801, 1'b0);
		add_entry(OP_WR, ADDR_ADV_LO,  8'h5a, 1'b1, 1'b0, 1'b0, 8'h00, 1'b1, 16'hd85a, 1'b0);
		add_entry(OP_RD, ADDR_ADV_LO,  8'h00, 1'b1, 1'b0, 1'b0, 8'h5a, 1'b1, 16'hd85a, 1'b0);
		// Back to MAC restores its image
		add_entry(OP_RD, ADDR_ADV_HI,  8'h00, 1'b0, 1'b0, 1'b0, 8'h40, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_ADV_LO,  8'h00, 1'b0, 1'b0, 1'b0, 8'h01, 1'b1, 16'h4001, 1'b0);
		// Status and link partner
		add_entry(OP_RD, ADDR_STAT_LO, 8'h00, 1'b0, 1'b0, 1'b1, 8'h20, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_STAT_LO, 8'h00, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_LP_LO, 8'h00, 1'b0, 1'b0, 1'b0, mr_lp_adv_ability[7:0], 1'b1,
			16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_LP_HI, 8'h00, 1'b0, 1'b0, 1'b0, mr_lp_adv_ability[15:8], 1'b1,
			16'h4001, 1'b0);
		// Page latch survives a high byte read and clears on the first low byte read
		add_entry(OP_RD, ADDR_PAGE_HI, 8'h00, 1'b0, 1'b1, 1'b0, 8'h00, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_PAGE_LO, 8'h00, 1'b0, 1'b0, 1'b0, 8'h02, 1'b1, 16'h4001, 1'b0);
		add_entry(OP_RD, ADDR_PAGE_LO, 8'h00, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1, 16'h4001, 1'b0);
		n_entries = t_wr.size();

		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		// Power-up reload
		repeat (SETTLE_CYCLES) @(posedge clk);
		for (int i = 0; i < n_entries; i++)
			run_entry(i);

		repeat (GAP_CYCLES) @(posedge clk);
		all_done = 1'b1;
		#1;
		if (err_count == 0 && test_count == n_entries &&
			i_an_reg_top.i_an_reg_assertions.fail_count == 0) begin
			$display("=== PASS ===");
		end else begin
			if (test_count != n_entries)
				$display("Only %0d of %0d accesses completed", test_count, n_entries);
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		#1;
		repeat (n_entries * CYCLES_PER_ENTRY + WATCHDOG_MARGIN) @(posedge clk);
		$display("Watchdog expired, the host bus never finished all accesses");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* sim/an_reg_assertions.sv */
`timescale 1ns/1ps

module an_reg_assertions (
	input logic clk,
	input logic rst_n,
	input logic hcs_n,
	input logic hready_n,
	input logic mr_main_reset,
	input logic mr_restart_an
);

	int fail_count = 0;

	// Ready is a one-cycle pulse
	ready_single: assert property (@(posedge clk) disable iff (!rst_n)
		!hready_n |=> hready_n)
		else begin
			fail_count++;
			$error("hready_n low for two cycles in a row");
		end

	// Ready only answers a selected access
	ready_with_cs: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(hready_n) |-> !$past(hcs_n))
		else begin
			fail_count++;
			$error("hready_n went low without chip select");
		end

	// Self-clearing bits, two cycles at most
	main_reset_len: assert property (@(posedge clk) disable iff (!rst_n)
		mr_main_reset && $past(mr_main_reset) |-> !$past(mr_main_reset, 2))
		else begin
			fail_count++;
			$error("mr_main_reset high for more than 2 cycles");
		end

	restart_len: assert property (@(posedge clk) disable iff (!rst_n)
		mr_restart_an && $past(mr_restart_an) |-> !$past(mr_restart_an, 2))
		else begin
			fail_count++;
			$error("mr_restart_an high for more than 2 cycles");
		end

endmodule

bind an_reg_top an_reg_assertions i_an_reg_assertions (
	.clk           (clk),
	.rst_n         (rst_n),
	.hcs_n         (hcs_n),
	.hready_n      (hready_n),
	.mr_main_reset (mr_main_reset),
	.mr_restart_an (mr_restart_an)
);

/* sim/an_reg_checker.sv */
`timescale 1ns/1ps

module an_reg_checker
	import an_regs_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       hready_n,
	input  host_data_t hdataout,
	input  logic       mr_main_reset,
	input  logic       mr_restart_an,
	input  logic       mr_an_enable,
	input  mii_reg_t   mr_adv_ability,
	// Expectation of the access in flight
	input  int         test_idx,
	input  logic       test_rd,
	input  host_data_t exp_byte,
	input  logic       exp_en,
	input  mii_reg_t   exp_adv,
	input  logic       exp_pulse,
	input  logic       all_done,
	output int         err_count,
	output int         test_count
);

	int errs = 0;
	int tests = 0;
	int line_errs = 0;
	// Consecutive high cycles of the self-clearing bits
	int main_len = 0;
	int restart_len = 0;

	assign err_count  = errs;
	assign test_count = tests;

	task automatic compare_value(input string sig, input logic [15:0] exp_v,
		input logic [15:0] act_v);
		if (act_v !== exp_v) begin
			$display("Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp_v, act_v);
			errs++;
			line_errs++;
		end
	endtask

	// Falling edge, mid cycle, all outputs settled
	always @(negedge clk) begin
		if (rst_n) begin
			main_len    = mr_main_reset ? main_len + 1 : 0;
			restart_len = mr_restart_an ? restart_len + 1 : 0;
			if (main_len == 5) begin
				$display("mr_main_reset stayed high for more than 4 cycles");
				errs++;
			end
			if (restart_len == 5) begin
				$display("mr_restart_an stayed high for more than 4 cycles");
				errs++;
			end
			// Ready low marks the end of one access
			if (!hready_n) begin
				line_errs = 0;
				if (test_rd)
					compare_value("hdataout", 16'(exp_byte), 16'(hdataout));
				compare_value("mr_an_enable", 16'(exp_en), 16'(mr_an_enable));
				compare_value("mr_adv_ability", exp_adv, mr_adv_ability);
				compare_value("mr_main_reset", 16'(exp_pulse), 16'(mr_main_reset));
				compare_value("mr_restart_an", 16'(exp_pulse), 16'(mr_restart_an));
				tests++;
				if (line_errs == 0)
					$display("Test %0d ok", test_idx);
				else
					$display("Test %0d had %0d mismatches", test_idx, line_errs);
			end
		end
	end

	always @(posedge all_done)
		$display("Summary: %0d tests run, %0d errors", tests, errs);

endmodule

/* rtl/an_reg_top.sv */
`timescale 1ns/1ps

module an_reg_top
	import an_regs_pkg::*;
#(
	// Advertised ability after reload, PHY side
	parameter mii_reg_t ADV_INIT_PHY = 16'hd801,
	// Advertised ability after reload, MAC side
	parameter mii_reg_t ADV_INIT_MAC = 16'h4001
) (
	input  logic       clk,
	input  logic       rst_n,
	// 1 = PHY, 0 = MAC
	input  logic       sgmii_mode,

	// Host bus
	input  logic       hcs_n,
	input  logic       hwrite_n,
	input  host_addr_t haddr,
	input  host_data_t hdatain,
	output host_data_t hdataout,
	output logic       hready_n,

	// From the auto-negotiation engine
	input  logic       mr_an_complete,
	input  logic       mr_page_rx,
	input  mii_reg_t   mr_lp_adv_ability,

	// To the auto-negotiation engine
	output logic       mr_main_reset,
	output logic       mr_an_enable,
	output logic       mr_restart_an,
	output mii_reg_t   mr_adv_ability
);

	// Strobes, one cycle each
	logic       ctrl_wr_hi;
	logic       adv_wr_lo;
	logic       adv_wr_hi;
	logic       page_rd;
	host_data_t wdata;

	// Read words back into the mux
	mii_reg_t ctrl_word;
	mii_reg_t an_status_word;
	mii_reg_t page_word;

	host_bus_ctrl i_host_bus_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.hcs_n          (hcs_n),
		.hwrite_n       (hwrite_n),
		.haddr          (haddr),
		.hdatain        (hdatain),
		.ctrl_word      (ctrl_word),
		.an_status_word (an_status_word),
		.adv_word       (mr_adv_ability),
		.lp_word        (mr_lp_adv_ability),
		.page_word      (page_word),
		.hdataout       (hdataout),
		.hready_n       (hready_n),
		.wdata          (wdata),
		.ctrl_wr_hi     (ctrl_wr_hi),
		.adv_wr_lo      (adv_wr_lo),
		.adv_wr_hi      (adv_wr_hi),
		.page_rd        (page_rd)
	);

	an_control_reg i_an_control_reg (
		.clk           (clk),
		.rst_n         (rst_n),
		.ctrl_wr_hi    (ctrl_wr_hi),
		.wdata         (wdata),
		.ctrl_word     (ctrl_word),
		.mr_main_reset (mr_main_reset),
		.mr_an_enable  (mr_an_enable),
		.mr_restart_an (mr_restart_an)
	);

	adv_ability_reg #(
		.ADV_INIT_PHY (ADV_INIT_PHY),
		.ADV_INIT_MAC (ADV_INIT_MAC)
	) i_adv_ability_reg (
		.clk            (clk),
		.rst_n          (rst_n),
		.sgmii_mode     (sgmii_mode),
		.adv_wr_lo      (adv_wr_lo),
		.adv_wr_hi      (adv_wr_hi),
		.wdata          (wdata),
		.mr_adv_ability (mr_adv_ability)
	);

	an_status_regs i_an_status_regs (
		.clk            (clk),
		.rst_n          (rst_n),
		.mr_an_complete (mr_an_complete),
		.mr_page_rx     (mr_page_rx),
		.page_rd        (page_rd),
		.an_status_word (an_status_word),
		.page_word      (page_word)
	);

endmodule

/* rtl/an_status_regs.sv */
`timescale 1ns/1ps

module an_status_regs
	import an_regs_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     mr_an_complete,
	input  logic     mr_page_rx,
	// Read strobe on the page low byte
	input  logic     page_rd,
	output mii_reg_t an_status_word,
	output mii_reg_t page_word
);

	logic page_latched;
	logic rd_detect;
	logic rd_d1;
	logic rd_d2;
	logic clear_on_read;

	// Complete bit only, rest reads zero
	always_comb begin
		an_status_word = '0;
		an_status_word[STAT_AN_COMPLETE_BIT] = mr_an_complete;
	end

	//////////////////////////////////////////////////////////////////////
	// Clear on read
	//////////////////////////////////////////////////////////////////////

	// Clear lands well after the read data was sampled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_detect     <= 1'b0;
			rd_d1         <= 1'b0;
			rd_d2         <= 1'b0;
			clear_on_read <= 1'b0;
		end else begin
			rd_detect     <= page_rd;
			rd_d1         <= rd_detect;
			rd_d2         <= rd_d1;
			// Falling edge of the last stage
			clear_on_read <= rd_d2 & ~rd_d1;
		end
	end

	// Latch, clear wins over a new page
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			page_latched <= 1'b0;
		else if (clear_on_read)
			page_latched <= 1'b0;
		else if (mr_page_rx)
			page_latched <= 1'b1;
	end

	always_comb begin
		page_word = '0;
		page_word[PAGE_RX_BIT] = page_latched;
	end

endmodule

/* rtl/adv_ability_reg.sv */
`timescale 1ns/1ps

module adv_ability_reg
	import an_regs_pkg::*;
#(
	parameter mii_reg_t ADV_INIT_PHY = 16'hd801,
	parameter mii_reg_t ADV_INIT_MAC = 16'h4001
) (
	input  logic       clk,
	input  logic       rst_n,
	// Asynchronous to clk
	input  logic       sgmii_mode,
	input  logic       adv_wr_lo,
	input  logic       adv_wr_hi,
	input  host_data_t wdata,
	output mii_reg_t   mr_adv_ability
);

	// Power-up chain, fills with ones after reset
	logic [7:0] pwr_chain;
	logic       pwr_load;

	// Mode synchronizer, delay and change flag
	logic mode_s1;
	logic mode_s2;
	logic mode_d3;
	logic mode_change;

	logic     reload;
	mii_reg_t init_val;

	//////////////////////////////////////////////////////////////////////
	// One-time reload after reset
	//////////////////////////////////////////////////////////////////////

	// Pulse on the rising edge of the last stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pwr_chain <= '0;
			pwr_load  <= 1'b0;
		end else begin
			pwr_chain <= {pwr_chain[6:0], 1'b1};
			pwr_load  <= pwr_chain[6] & ~pwr_chain[7];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Mode change
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_s1     <= 1'b0;
			mode_s2     <= 1'b0;
			mode_d3     <= 1'b0;
			mode_change <= 1'b0;
		end else begin
			// Two-flop synchronizer
			mode_s1     <= sgmii_mode;
			mode_s2     <= mode_s1;
			// Delay, then compare
			mode_d3     <= mode_s2;
			mode_change <= mode_s2 ^ mode_d3;
		end
	end

	assign reload   = pwr_load | mode_change;
	// Synchronized mode picks the image
	assign init_val = mode_s2 ? ADV_INIT_PHY : ADV_INIT_MAC;

	//////////////////////////////////////////////////////////////////////
	// Register, reload beats a host write
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mr_adv_ability <= ADV_RESET_VALUE;
		end else if (reload) begin
			mr_adv_ability <= init_val;
		end else if (mode_s2) begin
			// Writable only from the PHY side
			if (adv_wr_lo)
				mr_adv_ability[7:0] <= wdata;
			if (adv_wr_hi)
				mr_adv_ability[15:8] <= wdata;
		end
	end

endmodule

/* rtl/an_control_reg.sv */
`timescale 1ns/1ps

module an_control_reg
	import an_regs_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ctrl_wr_hi,
	// High byte of the word, bits 15..8
	input  host_data_t wdata,
	output mii_reg_t   ctrl_word,
	output logic       mr_main_reset,
	output logic       mr_an_enable,
	output logic       mr_restart_an
);

	// One-cycle copies for the self clear
	logic main_reset_d;
	logic restart_an_d;

	// Write, then clear once the delayed copy is seen
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mr_main_reset <= 1'b0;
			mr_an_enable  <= 1'b1;
			mr_restart_an <= 1'b0;
			main_reset_d  <= 1'b0;
			restart_an_d  <= 1'b0;
		end else begin
			if (ctrl_wr_hi) begin
				mr_main_reset <= wdata[CTRL_MAIN_RESET_BIT - 8];
				mr_an_enable  <= wdata[CTRL_AN_ENABLE_BIT - 8];
				mr_restart_an <= wdata[CTRL_RESTART_AN_BIT - 8];
			end
			main_reset_d <= mr_main_reset;
			restart_an_d <= mr_restart_an;
			// Net result is a two-cycle pulse
			if (main_reset_d)
				mr_main_reset <= 1'b0;
			if (restart_an_d)
				mr_restart_an <= 1'b0;
		end
	end

	// Unimplemented bits read zero
	always_comb begin
		ctrl_word = '0;
		ctrl_word[CTRL_MAIN_RESET_BIT] = mr_main_reset;
		ctrl_word[CTRL_AN_ENABLE_BIT]  = mr_an_enable;
		ctrl_word[CTRL_RESTART_AN_BIT] = mr_restart_an;
	end

endmodule

/* rtl/host_bus_ctrl.sv */
`timescale 1ns/1ps

module host_bus_ctrl
	import an_regs_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// Host side
	input  logic       hcs_n,
	input  logic       hwrite_n,
	input  host_addr_t haddr,
	input  host_data_t hdatain,
	output host_data_t hdataout,
	output logic       hready_n,

	// Register words for the read mux
	input  mii_reg_t   ctrl_word,
	input  mii_reg_t   an_status_word,
	input  mii_reg_t   adv_word,
	input  mii_reg_t   lp_word,
	input  mii_reg_t   page_word,

	// Register side strobes
	output host_data_t wdata,
	output logic       ctrl_wr_hi,
	output logic       adv_wr_lo,
	output logic       adv_wr_hi,
	output logic       page_rd
);

	logic hcs_n_d;
	// High for the one cycle after chip select is first seen low
	logic ack_pulse;
	logic ack_wr;
	logic ack_rd;

	//////////////////////////////////////////////////////////////////////
	// Handshake
	//////////////////////////////////////////////////////////////////////

	// Falling edge of chip select gives the acknowledge,
	// ready follows one cycle later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hcs_n_d   <= 1'b1;
			ack_pulse <= 1'b0;
			hready_n  <= 1'b1;
		end else begin
			hcs_n_d   <= hcs_n;
			ack_pulse <= ~hcs_n & hcs_n_d;
			hready_n  <= ~ack_pulse;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address decode, only in the acknowledge cycle
	//////////////////////////////////////////////////////////////////////

	assign ack_wr = ack_pulse & ~hwrite_n;
	assign ack_rd = ack_pulse & hwrite_n;

	// Control low byte has nothing writable
	assign ctrl_wr_hi = ack_wr & (haddr == ADDR_CTRL_HI);
	assign adv_wr_lo  = ack_wr & (haddr == ADDR_ADV_LO);
	assign adv_wr_hi  = ack_wr & (haddr == ADDR_ADV_HI);
	// Page latch clears on a read of its low byte
	assign page_rd    = ack_rd & (haddr == ADDR_PAGE_LO);

	// Same byte lands in whichever half is strobed
	assign wdata = hdatain;

	//////////////////////////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////////////////////////

	// Sampled every cycle, stable by the time ready is low
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hdataout <= '0;
		end else begin
			case (haddr)
				ADDR_CTRL_LO: hdataout <= ctrl_word[7:0];
				ADDR_CTRL_HI: hdataout <= ctrl_word[15:8];
				ADDR_STAT_LO: hdataout <= an_status_word[7:0];
				ADDR_STAT_HI: hdataout <= an_status_word[15:8];
				ADDR_ADV_LO:  hdataout <= adv_word[7:0];
				ADDR_ADV_HI:  hdataout <= adv_word[15:8];
				ADDR_LP_LO:   hdataout <= lp_word[7:0];
				ADDR_LP_HI:   hdataout <= lp_word[15:8];
				ADDR_PAGE_LO: hdataout <= page_word[7:0];
				ADDR_PAGE_HI: hdataout <= page_word[15:8];
				// Unmapped holes read zero
				default:      hdataout <= '0;
			endcase
		end
	end

endmodule

/* rtl/an_regs_pkg.sv */
package an_regs_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// Host byte address
	typedef logic [3:0] host_addr_t;
	// Host data byte
	typedef logic [7:0] host_data_t;
	// One management register word
	typedef logic [15:0] mii_reg_t;

	//////////////////////////////////////////////////////////////////////
	// Byte addresses, low and high half of each register
	//////////////////////////////////////////////////////////////////////

	// Control
	localparam host_addr_t ADDR_CTRL_LO = 4'd0;
	localparam host_addr_t ADDR_CTRL_HI = 4'd1;
	// Status
	localparam host_addr_t ADDR_STAT_LO = 4'd2;
	localparam host_addr_t ADDR_STAT_HI = 4'd3;
	// Advertised ability
	localparam host_addr_t ADDR_ADV_LO  = 4'd8;
	localparam host_addr_t ADDR_ADV_HI  = 4'd9;
	// Link partner ability
	localparam host_addr_t ADDR_LP_LO   = 4'd10;
	localparam host_addr_t ADDR_LP_HI   = 4'd11;
	// Page received
	localparam host_addr_t ADDR_PAGE_LO = 4'd12;
	localparam host_addr_t ADDR_PAGE_HI = 4'd13;

	//////////////////////////////////////////////////////////////////////
	// Bit positions within a 16-bit word
	//////////////////////////////////////////////////////////////////////

	// Control, all three in the high byte
	localparam int CTRL_MAIN_RESET_BIT  = 15;
	localparam int CTRL_AN_ENABLE_BIT   = 12;
	localparam int CTRL_RESTART_AN_BIT  = 9;
	// Status and page
	localparam int STAT_AN_COMPLETE_BIT = 5;
	localparam int PAGE_RX_BIT          = 1;

	// Held from reset until the first mode reload
	localparam mii_reg_t ADV_RESET_VALUE = 16'h4001;

endpackage
